//--- de0_io.f
hw/de0_io_pkg.sv
hw/heartbeat_divider.sv
hw/hex_display.sv
hw/io_registers.sv
hw/axil_slave.sv
hw/de0_io_top.sv
sim/de0_io_checker.sv
sim/tb_de0_io.sv

//--- sim/tb_de0_io.sv
module tb_de0_io;

    timeunit 1ns;
    timeprecision 1ps;

    import de0_io_pkg::*;

    typedef enum logic [1:0] { op_write, op_read, op_both } op_t;

    typedef struct packed {
        op_t        op;
        addr_t      addr;
        data_t      data;
        logic [3:0] strb;
        switches_t  sw;
        buttons_t   key;
        data_t      exp_data;
        resp_t      exp_resp;
    } entry_t;

    logic            clock_50_MHz;
    logic            reset_n;
    axil_write_req_t write_req;
    axil_write_rsp_t write_rsp;
    axil_read_req_t  read_req;
    axil_read_rsp_t  read_rsp;
    switches_t       switches;
    buttons_t        key;
    logic [9:0]      ledr;
    segments_t       hex0;
    segments_t       hex1;
    segments_t       hex2;
    segments_t       hex3;
    segments_t       hex4;
    segments_t       hex5;
    data_t           exp_data;
    resp_t           exp_resp;
    int              error_count;
    int              check_count;
    int              errors_before;
    int unsigned     seed;
    entry_t          entries [$];

    de0_io_top #(.divider_width(4)) u_de0_io_top
    (
        .clock_50_MHz ( clock_50_MHz ),
        .reset_n      ( reset_n      ),
        .write_req    ( write_req    ),
        .write_rsp    ( write_rsp    ),
        .read_req     ( read_req     ),
        .read_rsp     ( read_rsp     ),
        .switches     ( switches     ),
        .key          ( key          ),
        .ledr         ( ledr         ),
        .hex0         ( hex0         ),
        .hex1         ( hex1         ),
        .hex2         ( hex2         ),
        .hex3         ( hex3         ),
        .hex4         ( hex4         ),
        .hex5         ( hex5         )
    );

    de0_io_checker u_de0_io_checker
    (
        .clock_50_MHz ( clock_50_MHz ),
        .reset_n      ( reset_n      ),
        .write_req    ( write_req    ),
        .write_rsp    ( write_rsp    ),
        .read_req     ( read_req     ),
        .read_rsp     ( read_rsp     ),
        .ledr         ( ledr         ),
        .hex0         ( hex0         ),
        .hex1         ( hex1         ),
        .hex2         ( hex2         ),
        .hex3         ( hex3         ),
        .hex4         ( hex4         ),
        .hex5         ( hex5         ),
        .exp_data     ( exp_data     ),
        .exp_resp     ( exp_resp     ),
        .error_count  ( error_count  ),
        .check_count  ( check_count  )
    );

    initial
    begin
        clock_50_MHz = 1'b0;
        forever
            #10 clock_50_MHz = ~clock_50_MHz;
    end

    task automatic add_entry(input op_t op, input addr_t addr, input data_t data,
                             input logic [3:0] strb, input switches_t sw, input buttons_t keys,
                             input data_t want_data, input resp_t want_resp);
        entries.push_back({op, addr, data, strb, sw, keys, want_data, want_resp});
    endtask

    // Returns 1 ns after a rising edge.
    task automatic idle_cycles(input int unsigned count);
        if (count > 0)
        begin
            repeat (count)
                @(posedge clock_50_MHz);
            #1;
        end
    endtask

    task automatic write_transfer(input addr_t addr, input data_t data, input logic [3:0] strb);
        int unsigned delay;

        delay = $urandom_range(3);
        write_req.awvalid = 1'b1;
        write_req.awaddr  = addr;
        write_req.wvalid  = 1'b1;
        write_req.wdata   = data;
        write_req.wstrb   = strb;
        @(negedge clock_50_MHz);
        while (!write_rsp.awready)
            @(negedge clock_50_MHz);
        idle_cycles(1);
        write_req.awvalid = 1'b0;
        write_req.wvalid  = 1'b0;
        idle_cycles(delay);
        write_req.bready = 1'b1;
        @(negedge clock_50_MHz);
        while (!write_rsp.bvalid)
            @(negedge clock_50_MHz);
        idle_cycles(1);
        write_req.bready = 1'b0;
    endtask

    task automatic read_transfer(input addr_t addr);
        int unsigned delay;

        delay = $urandom_range(3);
        read_req.arvalid = 1'b1;
        read_req.araddr  = addr;
        @(negedge clock_50_MHz);
        while (!read_rsp.arready)
            @(negedge clock_50_MHz);
        idle_cycles(1);
        read_req.arvalid = 1'b0;
        idle_cycles(delay);
        read_req.rready = 1'b1;
        @(negedge clock_50_MHz);
        while (!read_rsp.rvalid)
            @(negedge clock_50_MHz);
        idle_cycles(1);
        read_req.rready = 1'b0;
    endtask

    task automatic run_entry(input entry_t entry);
        switches = entry.sw;
        key      = entry.key;
        exp_data = entry.exp_data;
        exp_resp = entry.exp_resp;
        // Let the pins pass the two synchronizer flops.
        idle_cycles(3);
        case (entry.op)
            op_write: write_transfer(entry.addr, entry.data, entry.strb);
            op_read:  read_transfer(entry.addr);
            default:
                fork
                    write_transfer(entry.addr, entry.data, entry.strb);
                    read_transfer(entry.addr);
                join
        endcase
    endtask

    initial
    begin
        seed = 21;
        void'($urandom(seed));
        reset_n   = 1'b0;
        write_req = '0;
        read_req  = '0;
        switches  = '0;
        key       = '1;
        exp_data  = '0;
        exp_resp  = resp_okay;

        add_entry(op_read,  addr_red_leds,   32'h0,         4'hF, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_green_leds, 32'h0,         4'hF, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_write, addr_red_leds,   32'h0003_9B8E, 4'hF, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_red_leds,   32'h0, 4'hF, 10'h0, 4'hF, 32'h0003_9B8E, resp_okay);
        add_entry(op_write, addr_red_leds,   32'h0001_7700, 4'h2, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_red_leds,   32'h0, 4'hF, 10'h0, 4'hF, 32'h0003_778E, resp_okay);
        add_entry(op_write, addr_red_leds,   32'h0002_0012, 4'h5, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_red_leds,   32'h0, 4'hF, 10'h0, 4'hF, 32'h0002_7712, resp_okay);
        add_entry(op_write, addr_green_leds, 32'h0000_01AB, 4'hF, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_green_leds, 32'h0,         4'hF, 10'h0,   4'hF, 32'h1AB, resp_okay);
        add_entry(op_write, addr_green_leds, 32'h0000_FE55, 4'h1, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_green_leds, 32'h0,         4'hF, 10'h0,   4'hF, 32'h155, resp_okay);
        add_entry(op_read,  addr_switches,   32'h0,         4'hF, 10'h2B5, 4'hF, 32'h2B5, resp_okay);
        add_entry(op_read,  addr_buttons,    32'h0,         4'hF, 10'h2B5, 4'hA, 32'h5, resp_okay);
        add_entry(op_read,  addr_buttons,    32'h0,         4'hF, 10'h0,   4'h0, 32'hF, resp_okay);
        add_entry(op_write, addr_switches,   32'h0000_03FF, 4'hF, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_write, 32'h10,          32'hFFFF_FFFF, 4'hF, 10'h0,   4'hF, 32'h0, resp_slverr);
        add_entry(op_read,  32'h10,          32'h0,         4'hF, 10'h0,   4'hF, 32'h0, resp_slverr);
        add_entry(op_read,  32'h06,          32'h0,         4'hF, 10'h0,   4'hF, 32'h0, resp_slverr);
        add_entry(op_read,  addr_red_leds,   32'h0, 4'hF, 10'h0, 4'hF, 32'h0002_7712, resp_okay);
        add_entry(op_both,  addr_red_leds,   32'h0000_D6F0, 4'hF, 10'h0,   4'hF, 32'hD6F0, resp_okay);
        add_entry(op_both,  addr_green_leds, 32'h0000_00FF, 4'h3, 10'h0,   4'hF, 32'hFF, resp_okay);
        add_entry(op_write, addr_buttons,    32'h0000_000F, 4'hF, 10'h0,   4'hF, 32'h0, resp_okay);
        add_entry(op_read,  addr_green_leds, 32'h0,         4'hF, 10'h0,   4'hF, 32'hFF, resp_okay);

        fork
            begin
                repeat (entries.size() * 50 + 16)
                    @(posedge clock_50_MHz);
                $display("Run timed out: the DUT stopped answering the bus");
                $display("Test failed");
                $finish;
            end
        join_none

        idle_cycles(16);
        reset_n = 1'b1;

        for (int i = 0; i < entries.size(); i++)
        begin
            errors_before = error_count;
            run_entry(entries[i]);
            $display("entry %0d op %0d addr %h: %s", i, entries[i].op, entries[i].addr,
                     (error_count == errors_before) ? "ok" : "mismatch");
        end

        // A few more heartbeat periods.
        idle_cycles(40);
        $display("Ran %0d entries, %0d checks, %0d errors", entries.size(), check_count,
                 error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- sim/de0_io_checker.sv
module de0_io_checker
(
    input  logic                        clock_50_MHz,
    input  logic                        reset_n,
    input  de0_io_pkg::axil_write_req_t write_req,
    input  de0_io_pkg::axil_write_rsp_t write_rsp,
    input  de0_io_pkg::axil_read_req_t  read_req,
    input  de0_io_pkg::axil_read_rsp_t  read_rsp,
    input  logic [9:0]                  ledr,
    input  de0_io_pkg::segments_t       hex0,
    input  de0_io_pkg::segments_t       hex1,
    input  de0_io_pkg::segments_t       hex2,
    input  de0_io_pkg::segments_t       hex3,
    input  de0_io_pkg::segments_t       hex4,
    input  de0_io_pkg::segments_t       hex5,
    input  de0_io_pkg::data_t           exp_data,
    input  de0_io_pkg::resp_t           exp_resp,
    output int                          error_count,
    output int                          check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import de0_io_pkg::*;

    // Lit segments for 0 to F in gfedcba order and active high. The 9 has no bottom bar.
    localparam logic [0:15][6:0] lit_segments = {7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
        7'h7D, 7'h07, 7'h7F, 7'h67, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    red_leds_t   model_red;
    green_leds_t model_green;
    reg_index_t  model_index;
    int          cycles;
    data_t       byte_mask;
    logic        bvalid_waiting;
    logic        rvalid_waiting;
    resp_t       held_bresp;
    data_t       held_rdata;
    resp_t       held_rresp;

    assign byte_mask = {{8{write_req.wstrb[3]}}, {8{write_req.wstrb[2]}},
                        {8{write_req.wstrb[1]}}, {8{write_req.wstrb[0]}}};

    task automatic check_value(input string what, input data_t actual, input data_t expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    initial
    begin
        error_count    = 0;
        check_count    = 0;
        bvalid_waiting = 1'b0;
        rvalid_waiting = 1'b0;
    end

    // Reference model of the LED registers, the write index and the divider.
    always @(posedge clock_50_MHz or negedge reset_n)
    begin
        if (!reset_n)
        begin
            model_red   <= '0;
            model_green <= '0;
            model_index <= '0;
            cycles      <= 0;
        end
        else
        begin
            cycles <= cycles + 1;
            if (write_req.awvalid && write_req.wvalid && write_rsp.awready && write_rsp.wready)
            begin
                if (write_req.awaddr == addr_red_leds)
                    model_red <= red_leds_t'((model_red & ~byte_mask) |
                                             (write_req.wdata & byte_mask));
                if (write_req.awaddr == addr_green_leds)
                    model_green <= green_leds_t'((model_green & ~byte_mask) |
                                                 (write_req.wdata & byte_mask));
                if (write_req.awaddr == addr_red_leds || write_req.awaddr == addr_green_leds)
                    model_index <= write_req.awaddr[3:2];
            end
        end
    end

    always @(negedge clock_50_MHz)
    begin
        if (!reset_n)
            check_value("ready and valid in reset", {write_rsp.awready, write_rsp.wready,
                        write_rsp.bvalid, read_rsp.arready, read_rsp.rvalid}, '0);
        check_value("ledr[8:0]", ledr[8:0], model_green);
        check_value("heartbeat", ledr[9], (cycles >> 3) & 1);
        check_value("hex0", hex0, segments_t'(~lit_segments[model_red[3:0]]));
        check_value("hex1", hex1, segments_t'(~lit_segments[model_red[7:4]]));
        check_value("hex2", hex2, segments_t'(~lit_segments[model_red[11:8]]));
        check_value("hex3", hex3, segments_t'(~lit_segments[model_red[15:12]]));
        check_value("hex4", hex4, segments_t'(~lit_segments[{2'b00, model_red[17:16]}]));
        check_value("hex5", hex5, segments_t'(~lit_segments[{2'b00, model_index}]));

        if (read_rsp.rvalid && write_req.awvalid)
        begin
            error_count++;
            $display("Read answered at %0d ns while a write was still waiting", $time);
        end

        if (write_rsp.bvalid)
        begin
            if (bvalid_waiting)
                check_value("bresp under back-pressure", write_rsp.bresp, held_bresp);
            held_bresp     = write_rsp.bresp;
            bvalid_waiting = !write_req.bready;
            if (write_req.bready)
                check_value("bresp", write_rsp.bresp, exp_resp);
        end

        if (read_rsp.rvalid)
        begin
            if (rvalid_waiting)
            begin
                check_value("rdata under back-pressure", read_rsp.rdata, held_rdata);
                check_value("rresp under back-pressure", read_rsp.rresp, held_rresp);
            end
            held_rdata     = read_rsp.rdata;
            held_rresp     = read_rsp.rresp;
            rvalid_waiting = !read_req.rready;
            if (read_req.rready)
            begin
                check_value("rdata", read_rsp.rdata, exp_data);
                check_value("rresp", read_rsp.rresp, exp_resp);
            end
        end
    end

endmodule

//--- hw/de0_io_top.sv
module de0_io_top
#(
    parameter int divider_width = de0_io_pkg::default_divider_width
)
(
    input  logic                        clock_50_MHz,
    input  logic                        reset_n,

    input  de0_io_pkg::axil_write_req_t write_req,
    output de0_io_pkg::axil_write_rsp_t write_rsp,
    input  de0_io_pkg::axil_read_req_t  read_req,
    output de0_io_pkg::axil_read_rsp_t  read_rsp,

    input  de0_io_pkg::switches_t       switches,
    input  de0_io_pkg::buttons_t        key,

    output logic [9:0]                  ledr,

    output de0_io_pkg::segments_t       hex0,
    output de0_io_pkg::segments_t       hex1,
    output de0_io_pkg::segments_t       hex2,
    output de0_io_pkg::segments_t       hex3,
    output de0_io_pkg::segments_t       hex4,
    output de0_io_pkg::segments_t       hex5
);

    import de0_io_pkg::*;

    reg_access_t access;
    reg_result_t result;
    red_leds_t   red_leds;
    green_leds_t green_leds;
    reg_index_t  last_index;
    logic        heartbeat;

    axil_slave u_axil_slave
    (
        .clock_50_MHz ( clock_50_MHz ),
        .reset_n      ( reset_n      ),
        .write_req    ( write_req    ),
        .write_rsp    ( write_rsp    ),
        .read_req     ( read_req     ),
        .read_rsp     ( read_rsp     ),
        .access       ( access       ),
        .result       ( result       )
    );

    io_registers u_io_registers
    (
        .clock_50_MHz ( clock_50_MHz ),
        .reset_n      ( reset_n      ),
        .access       ( access       ),
        .result       ( result       ),
        .switches     ( switches     ),
        .key          ( key          ),
        .red_leds     ( red_leds     ),
        .green_leds   ( green_leds   ),
        .last_index   ( last_index   )
    );

    heartbeat_divider #(.width(divider_width)) u_heartbeat_divider
    (
        .clock_50_MHz ( clock_50_MHz ),
        .reset_n      ( reset_n      ),
        .heartbeat    ( heartbeat    )
    );

    hex_display u_hex_display
    (
        .red_leds     ( red_leds     ),
        .last_index   ( last_index   ),
        .hex0         ( hex0         ),
        .hex1         ( hex1         ),
        .hex2         ( hex2         ),
        .hex3         ( hex3         ),
        .hex4         ( hex4         ),
        .hex5         ( hex5         )
    );

    // Heartbeat sits above the green LEDs.
    assign ledr = { heartbeat, green_leds };

endmodule

//--- hw/axil_slave.sv
module axil_slave
(
    input  logic                        clock_50_MHz,
    input  logic                        reset_n,

    input  de0_io_pkg::axil_write_req_t write_req,
    output de0_io_pkg::axil_write_rsp_t write_rsp,
    input  de0_io_pkg::axil_read_req_t  read_req,
    output de0_io_pkg::axil_read_rsp_t  read_rsp,

    output de0_io_pkg::reg_access_t     access,
    input  de0_io_pkg::reg_result_t     result
);

    import de0_io_pkg::*;

    axil_state_t state;
    axil_state_t state_next;

    logic        write_accept;
    logic        read_accept;

    resp_t       bresp_reg;
    data_t       rdata_reg;
    resp_t       rresp_reg;

    // Only idle accepts, so one transaction at most is in flight.
    // A write needs both address and data, and wins over a read.
    assign write_accept = (state == idle) && write_req.awvalid && write_req.wvalid;
    assign read_accept  = (state == idle) && !write_accept && read_req.arvalid;

    always_comb
    begin
        state_next = state;

        case (state)
            idle:
            begin
                if (write_accept)
                    state_next = write_resp;
                else if (read_accept)
                    state_next = read_resp;
            end

            write_resp:
            begin
                if (write_req.bready)
                    state_next = idle;
            end

            read_resp:
            begin
                if (read_req.rready)
                    state_next = idle;
            end

            default:
            begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clock_50_MHz or negedge reset_n)
    begin
        if (!reset_n)
            state <= idle;
        else
            state <= state_next;
    end

    // The register block answers in the same cycle as the strobe.
    always_ff @(posedge clock_50_MHz)
    begin
        if (write_accept)
            bresp_reg <= result.error ? resp_slverr : resp_okay;

        if (read_accept)
        begin
            rdata_reg <= result.rdata;
            rresp_reg <= result.error ? resp_slverr : resp_okay;
        end
    end

    always_comb
    begin
        write_rsp.awready = write_accept;
        write_rsp.wready  = write_accept;
        write_rsp.bvalid  = (state == write_resp);
        write_rsp.bresp   = bresp_reg;
    end

    always_comb
    begin
        read_rsp.arready  = read_accept;
        read_rsp.rvalid   = (state == read_resp);
        read_rsp.rdata    = rdata_reg;
        read_rsp.rresp    = rresp_reg;
    end

    always_comb
    begin
        access.write_strobe = write_accept;
        access.read_strobe  = read_accept;
        access.address      = write_accept ? write_req.awaddr : read_req.araddr;
        access.wdata        = write_req.wdata;
        access.wstrb        = write_req.wstrb;
    end

endmodule

//--- hw/io_registers.sv
module io_registers
(
    input  logic                        clock_50_MHz,
    input  logic                        reset_n,

    input  de0_io_pkg::reg_access_t     access,
    output de0_io_pkg::reg_result_t     result,

    input  de0_io_pkg::switches_t       switches,
    input  de0_io_pkg::buttons_t        key,

    output de0_io_pkg::red_leds_t       red_leds,
    output de0_io_pkg::green_leds_t     green_leds,
    output de0_io_pkg::reg_index_t      last_index
);

    import de0_io_pkg::*;

    typedef struct packed {
        buttons_t  buttons;
        switches_t switches;
    } pins_t;

    pins_t pins_meta;
    pins_t pins_sync;

    logic  write_red;
    logic  write_green;
    data_t read_data;

    // Two flops on the board inputs. KEY is active low, buttons active high.
    always_ff @(posedge clock_50_MHz or negedge reset_n)
    begin
        if (!reset_n)
        begin
            pins_meta <= '0;
            pins_sync <= '0;
        end
        else
        begin
            pins_meta <= '{buttons: ~key, switches: switches};
            pins_sync <= pins_meta;
        end
    end

    assign write_red   = access.write_strobe && (access.address == addr_red_leds);
    assign write_green = access.write_strobe && (access.address == addr_green_leds);

    always_ff @(posedge clock_50_MHz or negedge reset_n)
    begin
        if (!reset_n)
        begin
            red_leds   <= '0;
            green_leds <= '0;
            last_index <= '0;
        end
        else
        begin
            if (write_red)
            begin
                if (access.wstrb[0])
                    red_leds[7:0]   <= access.wdata[7:0];
                if (access.wstrb[1])
                    red_leds[15:8]  <= access.wdata[15:8];
                if (access.wstrb[2])
                    red_leds[17:16] <= access.wdata[17:16];
            end

            if (write_green)
            begin
                if (access.wstrb[0])
                    green_leds[7:0] <= access.wdata[7:0];
                if (access.wstrb[1])
                    green_leds[8]   <= access.wdata[8];
            end

            if (write_red || write_green)
                last_index <= access.address[3:2];
        end
    end

    // Anything outside the four words is an error and reads zero.
    always_comb
    begin
        read_data    = '0;
        result.error = 1'b0;

        case (access.address)
            addr_red_leds:   read_data = data_t'(red_leds);
            addr_green_leds: read_data = data_t'(green_leds);
            addr_switches:   read_data = data_t'(pins_sync.switches);
            addr_buttons:    read_data = data_t'(pins_sync.buttons);
            default:         result.error = 1'b1;
        endcase

        result.rdata = access.read_strobe ? read_data : '0;
    end

endmodule

//--- hw/hex_display.sv
module hex_display
(
    input  de0_io_pkg::red_leds_t   red_leds,
    input  de0_io_pkg::reg_index_t  last_index,

    output de0_io_pkg::segments_t   hex0,
    output de0_io_pkg::segments_t   hex1,
    output de0_io_pkg::segments_t   hex2,
    output de0_io_pkg::segments_t   hex3,
    output de0_io_pkg::segments_t   hex4,
    output de0_io_pkg::segments_t   hex5
);

    import de0_io_pkg::*;

    // Segment order is g f e d c b a. A lit segment is 0.
    function automatic segments_t decode_digit(input logic [3:0] digit);
        segments_t segments;

        case (digit)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0011000;
            4'ha: segments = 7'b0001000;
            4'hb: segments = 7'b0000011;
            4'hc: segments = 7'b1000110;
            4'hd: segments = 7'b0100001;
            4'he: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase

        return segments;
    endfunction

    assign hex0 = decode_digit(red_leds[3:0]);
    assign hex1 = decode_digit(red_leds[7:4]);
    assign hex2 = decode_digit(red_leds[11:8]);
    assign hex3 = decode_digit(red_leds[15:12]);

    // Top two LED bits and the register index are padded to a digit.
    assign hex4 = decode_digit({ 2'b00, red_leds[17:16] });
    assign hex5 = decode_digit({ 2'b00, last_index });

endmodule

//--- hw/heartbeat_divider.sv
module heartbeat_divider
#(
    parameter int width = de0_io_pkg::default_divider_width
)
(
    input  logic clock_50_MHz,
    input  logic reset_n,
    output logic heartbeat
);

    logic [width - 1:0] counter;

    // Free running; wraps around.
    always_ff @(posedge clock_50_MHz or negedge reset_n)
    begin
        if (!reset_n)
            counter <= '0;
        else
            counter <= counter + 1'b1;
    end

    // MSB toggles every 2 ** (width - 1) cycles.
    assign heartbeat = counter[width - 1];

endmodule

//--- hw/de0_io_pkg.sv
package de0_io_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [17:0] red_leds_t;
    typedef logic [ 8:0] green_leds_t;
    typedef logic [ 9:0] switches_t;
    typedef logic [ 3:0] buttons_t;
    typedef logic [ 6:0] segments_t;   // Active low, g down to a.
    typedef logic [ 1:0] reg_index_t;
    typedef logic [ 1:0] resp_t;

    // Register map, one word per register.
    localparam addr_t addr_red_leds   = 32'h0000_0000;
    localparam addr_t addr_green_leds = 32'h0000_0004;
    localparam addr_t addr_switches   = 32'h0000_0008;
    localparam addr_t addr_buttons    = 32'h0000_000C;

    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    // 50 MHz / 2 ** 26 gives a heartbeat of about 0.75 Hz.
    localparam int default_divider_width = 26;

    typedef struct packed {
        logic        awvalid;
        addr_t       awaddr;
        logic        wvalid;
        data_t       wdata;
        logic [3:0]  wstrb;
        logic        bready;
    } axil_write_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        resp_t       bresp;
    } axil_write_rsp_t;

    typedef struct packed {
        logic        arvalid;
        addr_t       araddr;
        logic        rready;
    } axil_read_req_t;

    typedef struct packed {
        logic        arready;
        logic        rvalid;
        data_t       rdata;
        resp_t       rresp;
    } axil_read_rsp_t;

    typedef struct packed {
        logic        write_strobe;
        logic        read_strobe;
        addr_t       address;
        data_t       wdata;
        logic [3:0]  wstrb;
    } reg_access_t;

    typedef struct packed {
        data_t       rdata;
        logic        error;
    } reg_result_t;

    typedef enum logic [1:0] {
        idle,
        write_resp,
        read_resp
    } axil_state_t;

endpackage
